// File: filelist.f
logic/hdmi_recv_pkg.sv
logic/video_input_sync.sv
logic/pixel_repacker.sv
logic/video_stats.sv
logic/pixel_fifo.sv
logic/axi_burst_writer.sv
logic/ctrl_regs.sv
logic/hdmi_recv.sv
sim/tb_clock_gen.sv
sim/hdmi_recv_tb.sv

// File: logic/axi_burst_writer.sv
module axi_burst_writer (
    input  logic                     clk_sys,
    input  logic                     hdmi_rst_n,
    input  logic                     dma_enable,
    input  hdmi_recv_pkg::axi_addr_t start_addr,
    input  logic                     start_addr_written,
    input  logic                     vs_rise,
    input  hdmi_recv_pkg::word_t     fifo_data,
    input  logic                     fifo_empty,
    input  hdmi_recv_pkg::fifo_cnt_t fifo_count,
    output logic                     fifo_rd_en,
    output hdmi_recv_pkg::axi_addr_t awaddr,
    output logic [7:0]               awlen,
    output logic [2:0]               awsize,
    output logic [1:0]               awburst,
    output logic                     awvalid,
    input  logic                     awready,
    output hdmi_recv_pkg::word_t     wdata,
    output logic [3:0]               wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    input  logic [1:0]               bresp,
    output logic                     bready
);

    import hdmi_recv_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_RESP} state_t;

    state_t                       state;
    logic [$clog2(BURST_LEN)-1:0] beat_cnt;
    axi_addr_t                    addr_ptr;     // next burst address
    logic                         err_hold;     // error response parks DMA till next frame
    logic                         w_fire;

    assign awlen      = 8'(BURST_LEN - 1);
    assign awsize     = AXI_SIZE_WORD;
    assign awburst    = AXI_BURST_INCR;
    assign awvalid    = (state == S_ADDR);
    assign wdata      = fifo_data;
    assign wstrb      = 4'hf;
    assign wvalid     = (state == S_DATA) & ~fifo_empty;
    assign wlast      = (beat_cnt == BURST_LEN - 1);
    assign w_fire     = wvalid & wready;
    assign fifo_rd_en = w_fire;
    assign bready     = 1'b1;

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
            addr_ptr <= '0;
            awaddr   <= '0;
            err_hold <= 1'b0;
        end else begin
            if (start_addr_written || vs_rise)
                err_hold <= 1'b0;
            else if (state == S_RESP && bvalid && bresp[1])
                err_hold <= 1'b1;

            // awaddr stays put while awvalid is high, the pointer may reload meanwhile
            if (start_addr_written || vs_rise)
                addr_ptr <= start_addr;
            else if (state == S_IDLE && dma_enable && !err_hold && fifo_count >= BURST_LEN)
                addr_ptr <= addr_ptr + BURST_BYTES;

            case (state)
                S_IDLE: begin
                    if (dma_enable && !err_hold && fifo_count >= BURST_LEN) begin
                        awaddr <= addr_ptr;
                        state  <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    beat_cnt <= '0;
                    if (awready)
                        state <= S_DATA;
                end
                S_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast)
                            state <= S_RESP;
                    end
                end
                default: begin
                    if (bvalid)
                        state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/ctrl_regs.sv
module ctrl_regs (
    input  logic                      clk_sys,
    input  logic                      hdmi_rst_n,
    input  hdmi_recv_pkg::ctrl_addr_t ctrl_address,
    input  logic                      ctrl_read,
    input  logic                      ctrl_write,
    input  hdmi_recv_pkg::word_t      ctrl_writedata,
    input  logic [3:0]                ctrl_byteenable,
    output hdmi_recv_pkg::word_t      ctrl_readdata,
    output logic [1:0]                ctrl_response,
    output logic                      ctrl_waitrequest,
    input  hdmi_recv_pkg::stat_cnt_t  line_pixels,
    input  hdmi_recv_pkg::stat_cnt_t  frame_lines,
    input  hdmi_recv_pkg::stat_cnt_t  frame_pixels,
    input  logic                      frame_done,
    input  logic                      fifo_overflow,
    output hdmi_recv_pkg::axi_addr_t  start_addr,
    output logic                      start_addr_written,
    output logic                      dma_enable
);

    import hdmi_recv_pkg::*;

    logic       rd_ack;        // second cycle of a read
    logic [1:0] status;        // sticky flags
    logic       status_rd;     // same edge that captures readdata

    assign ctrl_waitrequest = ctrl_read & ~rd_ack;
    assign ctrl_response    = 2'b00;
    assign status_rd        = ctrl_read & ~rd_ack & (ctrl_address == REG_STATUS);

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            rd_ack             <= 1'b0;
            start_addr         <= '0;
            start_addr_written <= 1'b0;
            dma_enable         <= 1'b0;
            status             <= '0;
        end else begin
            rd_ack             <= ctrl_read & ~rd_ack;
            start_addr_written <= ctrl_write & (ctrl_address == REG_START_ADDR);

            if (ctrl_write && ctrl_address == REG_START_ADDR) begin
                for (int i = 0; i < 4; i++) begin
                    if (ctrl_byteenable[i])
                        start_addr[8*i +: 8] <= ctrl_writedata[8*i +: 8];
                end
            end
            if (ctrl_write && ctrl_address == REG_CONTROL && ctrl_byteenable[0])
                dma_enable <= ctrl_writedata[0];

            // a new event wins over the clear
            status[STAT_FRAME_DONE] <= frame_done | (status[STAT_FRAME_DONE] & ~status_rd);
            status[STAT_OVERFLOW]   <= fifo_overflow | (status[STAT_OVERFLOW] & ~status_rd);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (ctrl_read && !rd_ack) begin
            case (ctrl_address)
                REG_START_ADDR:   ctrl_readdata <= start_addr;
                REG_CONTROL:      ctrl_readdata <= {31'd0, dma_enable};
                REG_LINE_PIXELS:  ctrl_readdata <= line_pixels;
                REG_FRAME_LINES:  ctrl_readdata <= frame_lines;
                REG_FRAME_PIXELS: ctrl_readdata <= frame_pixels;
                REG_STATUS:       ctrl_readdata <= {30'd0, status};
                default:          ctrl_readdata <= '0;     // unmapped
            endcase
        end
    end

endmodule

// File: logic/hdmi_recv.sv
module hdmi_recv (
    input  logic                      clk_sys,
    input  logic                      hdmi_rst_n,
    input  hdmi_recv_pkg::pixel_t     hdmi_data,
    input  logic                      hdmi_hs,
    input  logic                      hdmi_vs,
    input  logic                      hdmi_de,
    input  hdmi_recv_pkg::ctrl_addr_t ctrl_address,
    input  logic                      ctrl_read,
    input  logic                      ctrl_write,
    input  hdmi_recv_pkg::word_t      ctrl_writedata,
    input  logic [3:0]                ctrl_byteenable,
    output hdmi_recv_pkg::word_t      ctrl_readdata,
    output logic [1:0]                ctrl_response,
    output logic                      ctrl_waitrequest,
    output hdmi_recv_pkg::axi_addr_t  awaddr,
    output logic [7:0]                awlen,
    output logic [2:0]                awsize,
    output logic [1:0]                awburst,
    output logic                      awvalid,
    input  logic                      awready,
    output hdmi_recv_pkg::word_t      wdata,
    output logic [3:0]                wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    input  logic [1:0]                bresp,
    output logic                      bready
);

    import hdmi_recv_pkg::*;

    pixel_t    pixel;
    logic      de;
    logic      hs_rise;
    logic      vs_rise;
    logic      vs_fall;
    word_t     word;
    logic      word_valid;
    word_t     fifo_data;
    logic      fifo_empty;
    fifo_cnt_t fifo_count;
    logic      fifo_overflow;
    logic      fifo_rd_en;
    axi_addr_t start_addr;
    logic      start_addr_written;
    logic      dma_enable;
    stat_cnt_t line_pixels;
    stat_cnt_t frame_lines;
    stat_cnt_t frame_pixels;
    logic      frame_done;

    video_input_sync video_input_sync_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .hdmi_data  (hdmi_data),
        .hdmi_hs    (hdmi_hs),
        .hdmi_vs    (hdmi_vs),
        .hdmi_de    (hdmi_de),
        .pixel      (pixel),
        .de         (de),
        .hs_rise    (hs_rise),
        .vs_rise    (vs_rise),
        .vs_fall    (vs_fall)
    );

    pixel_repacker pixel_repacker_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .pixel      (pixel),
        .de         (de),
        .word       (word),
        .word_valid (word_valid)
    );

    video_stats video_stats_i (
        .clk_sys      (clk_sys),
        .hdmi_rst_n   (hdmi_rst_n),
        .de           (de),
        .hs_rise      (hs_rise),
        .vs_rise      (vs_rise),
        .vs_fall      (vs_fall),
        .line_pixels  (line_pixels),
        .frame_lines  (frame_lines),
        .frame_pixels (frame_pixels),
        .frame_done   (frame_done)
    );

    pixel_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) pixel_fifo_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .wr_data    (word),
        .wr_en      (word_valid),       // no back-pressure toward video
        .rd_en      (fifo_rd_en),
        .rd_data    (fifo_data),
        .empty      (fifo_empty),
        .count      (fifo_count),
        .overflow   (fifo_overflow)
    );

    axi_burst_writer axi_burst_writer_i (
        .clk_sys            (clk_sys),
        .hdmi_rst_n         (hdmi_rst_n),
        .dma_enable         (dma_enable),
        .start_addr         (start_addr),
        .start_addr_written (start_addr_written),
        .vs_rise            (vs_rise),
        .fifo_data          (fifo_data),
        .fifo_empty         (fifo_empty),
        .fifo_count         (fifo_count),
        .fifo_rd_en         (fifo_rd_en),
        .awaddr             (awaddr),
        .awlen              (awlen),
        .awsize             (awsize),
        .awburst            (awburst),
        .awvalid            (awvalid),
        .awready            (awready),
        .wdata              (wdata),
        .wstrb              (wstrb),
        .wlast              (wlast),
        .wvalid             (wvalid),
        .wready             (wready),
        .bvalid             (bvalid),
        .bresp              (bresp),
        .bready             (bready)
    );

    ctrl_regs ctrl_regs_i (
        .clk_sys            (clk_sys),
        .hdmi_rst_n         (hdmi_rst_n),
        .ctrl_address       (ctrl_address),
        .ctrl_read          (ctrl_read),
        .ctrl_write         (ctrl_write),
        .ctrl_writedata     (ctrl_writedata),
        .ctrl_byteenable    (ctrl_byteenable),
        .ctrl_readdata      (ctrl_readdata),
        .ctrl_response      (ctrl_response),
        .ctrl_waitrequest   (ctrl_waitrequest),
        .line_pixels        (line_pixels),
        .frame_lines        (frame_lines),
        .frame_pixels       (frame_pixels),
        .frame_done         (frame_done),
        .fifo_overflow      (fifo_overflow),
        .start_addr         (start_addr),
        .start_addr_written (start_addr_written),
        .dma_enable         (dma_enable)
    );

endmodule

// File: logic/hdmi_recv_pkg.sv
package hdmi_recv_pkg;

    typedef logic [23:0] pixel_t;       // byte 0 in bits 7..0
    typedef logic [31:0] word_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [7:0]  ctrl_addr_t;
    typedef logic [31:0] stat_cnt_t;
    typedef logic [6:0]  fifo_cnt_t;    // holds 0..FIFO_DEPTH

    localparam int BURST_LEN   = 16;    // beats per burst
    localparam int BURST_BYTES = 64;    // 16 beats of 4 bytes
    localparam int FIFO_DEPTH  = 64;

    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    localparam ctrl_addr_t REG_START_ADDR   = 8'h00;
    localparam ctrl_addr_t REG_CONTROL      = 8'h04;    // bit 0 dma_enable
    localparam ctrl_addr_t REG_LINE_PIXELS  = 8'h08;
    localparam ctrl_addr_t REG_FRAME_LINES  = 8'h0C;
    localparam ctrl_addr_t REG_FRAME_PIXELS = 8'h10;
    localparam ctrl_addr_t REG_STATUS       = 8'h14;    // clears on read

    localparam int STAT_FRAME_DONE = 0;
    localparam int STAT_OVERFLOW   = 1;

endpackage

// File: logic/pixel_fifo.sv
module pixel_fifo #(
    parameter int DEPTH = hdmi_recv_pkg::FIFO_DEPTH
) (
    input  logic                     clk_sys,
    input  logic                     hdmi_rst_n,
    input  hdmi_recv_pkg::word_t     wr_data,
    input  logic                     wr_en,
    input  logic                     rd_en,
    output hdmi_recv_pkg::word_t     rd_data,
    output logic                     empty,
    output hdmi_recv_pkg::fifo_cnt_t count,
    output logic                     overflow
);

    import hdmi_recv_pkg::*;

    word_t                    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     full;
    logic                     do_wr;
    logic                     do_rd;

    assign full    = (count == fifo_cnt_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr_en & ~full;
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem[rd_ptr];                   // head word, no read latency

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en & full;               // word is lost
            if (do_wr)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            count <= count + fifo_cnt_t'(do_wr) - fifo_cnt_t'(do_rd);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

// File: logic/pixel_repacker.sv
module pixel_repacker (
    input  logic                  clk_sys,
    input  logic                  hdmi_rst_n,
    input  hdmi_recv_pkg::pixel_t pixel,
    input  logic                  de,
    output hdmi_recv_pkg::word_t  word,
    output logic                  word_valid
);

    import hdmi_recv_pkg::*;

    logic [1:0]  phase;        // pixel position inside a group of four
    logic [23:0] hold;         // stream bytes not yet sent
    word_t       stage_word;
    logic        stage_valid;

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            phase       <= 2'd0;
            stage_valid <= 1'b0;
            word_valid  <= 1'b0;
        end else begin
            phase       <= de ? phase + 2'd1 : 2'd0;
            stage_valid <= de && (phase != 2'd0);   // phases 1..3 complete a word
            word_valid  <= stage_valid;
        end
    end

    // Word k carries stream bytes 4k..4k+3, lowest byte first.
    // Twelve bytes of four pixels come out as three words.
    always_ff @(posedge clk_sys) begin
        case (phase)
            2'd0: begin
                hold <= pixel;
            end
            2'd1: begin
                stage_word <= {pixel[7:0], hold[23:0]};
                hold[15:0] <= pixel[23:8];
            end
            2'd2: begin
                stage_word <= {pixel[15:0], hold[15:0]};
                hold[7:0]  <= pixel[23:16];
            end
            default: begin
                stage_word <= {pixel, hold[7:0]};
            end
        endcase
        word <= stage_word;
    end

endmodule

// File: logic/video_input_sync.sv
module video_input_sync (
    input  logic                  clk_sys,
    input  logic                  hdmi_rst_n,
    input  hdmi_recv_pkg::pixel_t hdmi_data,
    input  logic                  hdmi_hs,
    input  logic                  hdmi_vs,
    input  logic                  hdmi_de,
    output hdmi_recv_pkg::pixel_t pixel,
    output logic                  de,
    output logic                  hs_rise,
    output logic                  vs_rise,
    output logic                  vs_fall
);

    logic hs_q;
    logic vs_q;

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
            de      <= 1'b0;
            hs_rise <= 1'b0;
            vs_rise <= 1'b0;
            vs_fall <= 1'b0;
        end else begin
            hs_q    <= hdmi_hs;
            vs_q    <= hdmi_vs;
            de      <= hdmi_de;
            hs_rise <= hdmi_hs & ~hs_q;     // compare with last sample
            vs_rise <= hdmi_vs & ~vs_q;
            vs_fall <= ~hdmi_vs & vs_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        pixel <= hdmi_data;                 // lines up with de
    end

endmodule

// File: logic/video_stats.sv
module video_stats (
    input  logic                     clk_sys,
    input  logic                     hdmi_rst_n,
    input  logic                     de,
    input  logic                     hs_rise,
    input  logic                     vs_rise,
    input  logic                     vs_fall,
    output hdmi_recv_pkg::stat_cnt_t line_pixels,
    output hdmi_recv_pkg::stat_cnt_t frame_lines,
    output hdmi_recv_pkg::stat_cnt_t frame_pixels,
    output logic                     frame_done
);

    import hdmi_recv_pkg::*;

    stat_cnt_t line_cnt;       // de cycles in current line
    stat_cnt_t line_total;     // hs rises in current frame
    stat_cnt_t pix_total;      // de cycles in current frame

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            line_cnt     <= '0;
            line_total   <= '0;
            pix_total    <= '0;
            line_pixels  <= '0;
            frame_lines  <= '0;
            frame_pixels <= '0;
            frame_done   <= 1'b0;
        end else begin
            frame_done <= vs_fall;

            if (hs_rise) begin
                if (line_cnt != '0)
                    line_pixels <= line_cnt;    // blank lines keep last value
                line_cnt <= stat_cnt_t'(de);
            end else if (de) begin
                line_cnt <= line_cnt + 1'b1;
            end

            if (vs_rise) begin
                frame_lines  <= line_total;
                frame_pixels <= pix_total;
                line_total   <= stat_cnt_t'(hs_rise);
                pix_total    <= stat_cnt_t'(de);
            end else begin
                if (hs_rise)
                    line_total <= line_total + 1'b1;
                if (de)
                    pix_total <= pix_total + 1'b1;
            end
        end
    end

endmodule

// File: sim/hdmi_recv_tb.sv
module hdmi_recv_tb;

    import hdmi_recv_pkg::*;

    // longest test is about 250 cycles of video plus burst drain, so this is a wide margin
    localparam int MAX_CYCLES = 20000;
    localparam axi_addr_t CAPTURE_BASE = 32'h2000_0400;

    logic       clk_sys;
    logic       hdmi_rst_n;
    pixel_t     hdmi_data = '0;
    logic       hdmi_hs = 1'b0;
    logic       hdmi_vs = 1'b0;
    logic       hdmi_de = 1'b0;
    ctrl_addr_t ctrl_address = '0;
    logic       ctrl_read = 1'b0;
    logic       ctrl_write = 1'b0;
    word_t      ctrl_writedata = '0;
    logic [3:0] ctrl_byteenable = '0;
    word_t      ctrl_readdata;
    logic [1:0] ctrl_response;
    logic       ctrl_waitrequest;
    axi_addr_t  awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic       awvalid;
    logic       awready = 1'b0;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       wlast;
    logic       wvalid;
    logic       wready = 1'b0;
    logic       bvalid = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic       bready;

    string       test_name = "reset";
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    int          awvalid_cycles = 0;
    int          b_count = 0;
    int          pending_b = 0;
    int          beat = 0;
    int          pix_seq = 0;
    int unsigned rand_seed;
    axi_addr_t   aw_addr_q[$];
    word_t       wdata_q[$];
    logic [7:0]  exp_byte_q[$];

    tb_clock_gen clock_gen_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n)
    );

    hdmi_recv hdmi_recv_i (
        .clk_sys          (clk_sys),
        .hdmi_rst_n       (hdmi_rst_n),
        .hdmi_data        (hdmi_data),
        .hdmi_hs          (hdmi_hs),
        .hdmi_vs          (hdmi_vs),
        .hdmi_de          (hdmi_de),
        .ctrl_address     (ctrl_address),
        .ctrl_read        (ctrl_read),
        .ctrl_write       (ctrl_write),
        .ctrl_writedata   (ctrl_writedata),
        .ctrl_byteenable  (ctrl_byteenable),
        .ctrl_readdata    (ctrl_readdata),
        .ctrl_response    (ctrl_response),
        .ctrl_waitrequest (ctrl_waitrequest),
        .awaddr           (awaddr),
        .awlen            (awlen),
        .awsize           (awsize),
        .awburst          (awburst),
        .awvalid          (awvalid),
        .awready          (awready),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .wlast            (wlast),
        .wvalid           (wvalid),
        .wready           (wready),
        .bvalid           (bvalid),
        .bresp            (bresp),
        .bready           (bready)
    );

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // AXI slave model with random ready and response timing
    initial begin
        rand_seed = 32'haef0;
        void'($urandom(rand_seed));
        forever begin
            @(posedge clk_sys);
            if (hdmi_rst_n) begin
                if (awvalid)
                    awvalid_cycles++;
                if (awvalid && awready) begin
                    aw_addr_q.push_back(awaddr);
                    check_value("awlen", BURST_LEN - 1, awlen);
                    check_value("awsize", AXI_SIZE_WORD, awsize);
                    check_value("awburst", AXI_BURST_INCR, awburst);
                end
                if (bvalid && bready) begin
                    pending_b--;
                    b_count++;
                end
                if (wvalid && wready) begin
                    wdata_q.push_back(wdata);
                    check_value("wlast", 32'(beat == BURST_LEN - 1), wlast);
                    check_value("wstrb", 4'hf, wstrb);
                    if (beat == BURST_LEN - 1)
                        pending_b++;                    // response owed after last beat
                    beat = (beat == BURST_LEN - 1) ? 0 : beat + 1;
                end
                awready <= ($urandom % 4) != 0;
                wready  <= ($urandom % 4) != 0;
                bvalid  <= (pending_b > 0) && (($urandom % 2) == 0);
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic reg_write(ctrl_addr_t addr, word_t data, logic [3:0] be);
        @(posedge clk_sys);
        ctrl_write      <= 1'b1;
        ctrl_address    <= addr;
        ctrl_writedata  <= data;
        ctrl_byteenable <= be;
        @(posedge clk_sys);
        while (ctrl_waitrequest)
            @(posedge clk_sys);
        ctrl_write <= 1'b0;
    endtask

    task automatic reg_read(ctrl_addr_t addr, output word_t data);
        @(posedge clk_sys);
        ctrl_read    <= 1'b1;
        ctrl_address <= addr;
        @(posedge clk_sys);
        while (ctrl_waitrequest)
            @(posedge clk_sys);
        data = ctrl_readdata;
        check_value("response", 2'b00, ctrl_response);
        ctrl_read <= 1'b0;
    endtask

    task automatic read_expect(ctrl_addr_t addr, word_t expected, string what);
        word_t data;
        reg_read(addr, data);
        check_value(what, expected, data);
    endtask

    // vsync pulse, then lines of hsync, blanking and active pixels
    task automatic send_frame(int lines, int ppl, bit capture);
        pixel_t pix;
        @(posedge clk_sys);
        hdmi_vs <= 1'b1;
        repeat (3) @(posedge clk_sys);
        hdmi_vs <= 1'b0;
        repeat (4) @(posedge clk_sys);
        for (int l = 0; l < lines; l++) begin
            hdmi_hs <= 1'b1;
            @(posedge clk_sys);
            hdmi_hs <= 1'b0;
            repeat (3) @(posedge clk_sys);
            for (int p = 0; p < ppl; p++) begin
                pix = {pix_seq[7:0] ^ 8'ha5, pix_seq[7:0] + 8'h40, pix_seq[7:0]};
                hdmi_de   <= 1'b1;
                hdmi_data <= pix;
                if (capture && p < (ppl / 4) * 4) begin   // partial group is dropped
                    exp_byte_q.push_back(pix[7:0]);
                    exp_byte_q.push_back(pix[15:8]);
                    exp_byte_q.push_back(pix[23:16]);
                end
                pix_seq++;
                @(posedge clk_sys);
            end
            hdmi_de <= 1'b0;
            repeat (6) @(posedge clk_sys);
        end
    endtask

    task automatic capture_frame(int lines, int ppl);
        int b_target;
        aw_addr_q.delete();
        wdata_q.delete();
        exp_byte_q.delete();
        b_target = b_count + lines * (ppl / 4) * 3 / BURST_LEN;
        send_frame(lines, ppl, 1'b1);
        while (b_count < b_target)
            @(posedge clk_sys);
    endtask

    task automatic check_data();
        word_t exp_word;
        check_value("word count", exp_byte_q.size() / 4, wdata_q.size());
        for (int k = 0; k < wdata_q.size() && 4 * k + 3 < exp_byte_q.size(); k++) begin
            exp_word = {exp_byte_q[4*k+3], exp_byte_q[4*k+2], exp_byte_q[4*k+1], exp_byte_q[4*k]};
            check_value("wdata", exp_word, wdata_q[k]);
        end
    endtask

    task automatic check_addresses(int bursts);
        check_value("burst count", bursts, aw_addr_q.size());
        foreach (aw_addr_q[k])
            check_value("awaddr", CAPTURE_BASE + k * BURST_BYTES, aw_addr_q[k]);
    endtask

    task automatic end_test(int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - errs_before);
        end
    endtask

    task automatic test_registers();
        int errs;
        errs = error_count;
        test_name = "registers";
        reg_write(REG_START_ADDR, 32'h1122_3344, 4'hf);
        reg_write(REG_START_ADDR, 32'haabb_ccdd, 4'b0101);
        read_expect(REG_START_ADDR, 32'h11bb_33dd, "start_addr byte merge");
        reg_write(REG_CONTROL, 32'hffff_ffff, 4'hf);
        read_expect(REG_CONTROL, 32'h1, "control set");
        reg_write(REG_CONTROL, 32'h0, 4'hf);
        read_expect(REG_CONTROL, 32'h0, "control clear");
        read_expect(8'h18, 32'h0, "unmapped offset");
        end_test(errs);
    endtask

    task automatic test_capture();
        int errs;
        errs = error_count;
        test_name = "capture";
        reg_write(REG_START_ADDR, CAPTURE_BASE, 4'hf);
        reg_write(REG_CONTROL, 32'h1, 4'hf);
        capture_frame(4, 16);                   // 48 words, three bursts
        check_data();
        end_test(errs);
    endtask

    task automatic test_addresses();
        int errs;
        errs = error_count;
        test_name = "addresses";
        check_addresses(3);                     // bursts of the capture frame
        capture_frame(4, 16);
        check_addresses(3);                     // restarts at frame start
        check_data();
        end_test(errs);
    endtask

    task automatic test_statistics();
        int errs;
        errs = error_count;
        test_name = "statistics";
        read_expect(REG_LINE_PIXELS, 32'd16, "line pixels");
        read_expect(REG_FRAME_LINES, 32'd4, "frame lines");
        read_expect(REG_FRAME_PIXELS, 32'd64, "frame pixels");
        end_test(errs);
    endtask

    task automatic test_status();
        int errs;
        word_t data;
        errs = error_count;
        test_name = "status";
        reg_read(REG_STATUS, data);             // drop earlier flags
        capture_frame(4, 16);
        read_expect(REG_STATUS, 32'h1, "frame done set");
        read_expect(REG_STATUS, 32'h0, "status after read");
        end_test(errs);
    endtask

    task automatic test_overflow();
        int errs;
        int aw_before;
        word_t data;
        errs = error_count;
        test_name = "overflow";
        reg_write(REG_CONTROL, 32'h0, 4'hf);
        reg_read(REG_STATUS, data);
        aw_before = awvalid_cycles;
        send_frame(8, 16, 1'b0);                // 96 words into a 64 word FIFO
        repeat (8) @(posedge clk_sys);
        check_value("awvalid cycles", aw_before, awvalid_cycles);
        reg_read(REG_STATUS, data);
        check_value("overflow flag", 1, data[STAT_OVERFLOW]);
        read_expect(REG_STATUS, 32'h0, "status after read");
        end_test(errs);
    endtask

    initial begin
        @(posedge hdmi_rst_n);
        repeat (4) @(posedge clk_sys);
        test_registers();
        test_capture();
        test_addresses();
        test_statistics();
        test_status();
        test_overflow();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_sys,
    output logic hdmi_rst_n
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_sys = 1'b0;
        forever #HALF_PERIOD clk_sys = ~clk_sys;
    end

    initial begin
        hdmi_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        hdmi_rst_n <= 1'b1;
    end

endmodule
